// File: testbench/tcb_sys_stim.txt
# per initiator: name vld wen adr ben wdt exp_rdt exp_err (all hex)
# initiator 0 columns first, then initiator 1; one step per line
wr_rd 1 1 10 f 11223344 00000000 0   - 0 0 00 0 00000000 00000000 0
- 0 0 00 0 00000000 00000000 0   wr_rd 1 0 10 0 00000000 11223344 0
wr_rd 1 1 11 f a5a5a5a5 00000000 0   - 0 0 00 0 00000000 00000000 0
- 0 0 00 0 00000000 00000000 0   wr_rd 1 0 11 0 00000000 a5a5a5a5 0
prio 1 1 20 f 0badf00d 00000000 0   prio 1 1 21 f cafe0001 00000000 0
prio 1 0 21 0 00000000 cafe0001 0   prio 1 0 20 0 00000000 0badf00d 0
prio 1 0 10 0 00000000 11223344 0   prio 1 0 11 0 00000000 a5a5a5a5 0
prio 1 1 22 f 12345678 00000000 0   prio 1 0 20 0 00000000 0badf00d 0
prio 1 0 22 0 00000000 12345678 0   prio 1 1 23 f 87654321 00000000 0
prio 1 0 23 0 00000000 87654321 0   prio 1 0 22 0 00000000 12345678 0
ben 1 1 30 f 00000000 00000000 0   - 0 0 00 0 00000000 00000000 0
ben 1 1 30 1 aaaaaa11 00000000 0   - 0 0 00 0 00000000 00000000 0
- 0 0 00 0 00000000 00000000 0   ben 1 1 30 4 ff22ffff 00000000 0
ben 1 0 30 0 00000000 00220011 0   - 0 0 00 0 00000000 00000000 0
ben 1 1 30 a 5566aabb 00000000 0   - 0 0 00 0 00000000 00000000 0
- 0 0 00 0 00000000 00000000 0   ben 1 0 30 0 00000000 5522aa11 0
ben 1 1 31 f deadbeef 00000000 0   ben 1 1 31 c 1234ffff 00000000 0
ben 1 0 31 0 00000000 1234beef 0   - 0 0 00 0 00000000 00000000 0
ben 1 1 32 f 00000000 00000000 0   ben 1 1 33 f ffffffff 00000000 0
ben 1 1 33 6 00abcd00 00000000 0   ben 1 1 32 9 77000088 00000000 0
ben 1 0 32 0 00000000 77000088 0   ben 1 0 33 0 00000000 ffabcdff 0
range 1 0 80 0 00000000 00000000 1   - 0 0 00 0 00000000 00000000 0
range 1 1 90 f 11111111 00000000 1   - 0 0 00 0 00000000 00000000 0
- 0 0 00 0 00000000 00000000 0   range 1 0 10 0 00000000 11223344 0
range 1 1 ff f 22222222 00000000 1   range 1 1 7f f 7f7f7f7f 00000000 0
range 1 0 7f 0 00000000 7f7f7f7f 0   range 1 0 80 0 00000000 00000000 1
range 1 1 91 f 99999999 00000000 1   - 0 0 00 0 00000000 00000000 0
range 1 0 11 0 00000000 a5a5a5a5 0   range 1 0 7f 0 00000000 7f7f7f7f 0
backpr 1 1 40 f 00000040 00000000 0   - 0 0 00 0 00000000 00000000 0
backpr 1 1 41 f 00000041 00000000 0   - 0 0 00 0 00000000 00000000 0
backpr 1 1 42 f 00000042 00000000 0   - 0 0 00 0 00000000 00000000 0
backpr 1 1 43 f 00000043 00000000 0   - 0 0 00 0 00000000 00000000 0
- 0 0 00 0 00000000 00000000 0   backpr 1 1 44 f 00000044 00000000 0
- 0 0 00 0 00000000 00000000 0   backpr 1 1 45 f 00000045 00000000 0
backpr 1 1 46 f 00000046 00000000 0   backpr 1 1 47 f 00000047 00000000 0
backpr 1 0 40 0 00000000 00000040 0   backpr 1 0 44 0 00000000 00000044 0
backpr 1 0 41 0 00000000 00000041 0   backpr 1 0 45 0 00000000 00000045 0
backpr 1 0 42 0 00000000 00000042 0   backpr 1 0 46 0 00000000 00000046 0
backpr 1 0 43 0 00000000 00000043 0   backpr 1 0 47 0 00000000 00000047 0
final 1 0 30 0 00000000 5522aa11 0   final 1 0 31 0 00000000 1234beef 0
final 1 0 21 0 00000000 cafe0001 0   final 1 0 20 0 00000000 0badf00d 0
final 1 0 80 0 00000000 00000000 1   final 1 0 10 0 00000000 11223344 0

// File: tcb_sys.f
verilog/tcb_pkg.sv
verilog/tcb_arb.sv
verilog/tcb_mem.sv
verilog/tcb_sys.sv
testbench/tcb_sys_props.sv
testbench/tcb_sys_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the tcb subsystem testbench with verilator
# the run passes only if the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tcb_sys_tb \
  -f tcb_sys.f -o tcb_sys_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tcb_sys_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^All tests passed$"; then
  exit 0
else
  echo "pass line not found in simulation output"
  exit 1
fi

// File: testbench/tcb_sys_tb.sv
// testbench for the tcb subsystem
// file driven stimulus, one driver per initiator, checks, timeout, report

module tcb_sys_tb;

  import tcb_pkg::*;

  //////////////////////////////////////////////////
  // constants and signals
  //////////////////////////////////////////////////

  localparam int    MAX_STEPS = 64;
  localparam int    RST_CYC   = 16;
  localparam string STIM_FILE = "testbench/tcb_sys_stim.txt";

  logic     man;
  logic     rst_n;
  tcb_req_t ini_req [PN];
  tcb_rsp_t ini_rsp [PN];

  // stimulus table, one row per step
  tcb_req_t      stim_req  [MAX_STEPS][PN];
  logic [DW-1:0] stim_rdt  [MAX_STEPS][PN];
  logic          stim_err  [MAX_STEPS][PN];
  string         stim_name [MAX_STEPS][PN];
  int            nsteps;

  // cycle of the transfer, per initiator in the current step
  int done_cyc [PN];

  int cyc = 0;
  int limit = 100;
  int val_errs = 0;
  int other_errs = 0;
  int mon_errs = 0;

  tcb_sys dut0 (
    .man     (man),
    .rst_n   (rst_n),
    .ini_req (ini_req),
    .ini_rsp (ini_rsp)
  );

  always #5 man = ~man;

  //////////////////////////////////////////////////
  // monitors
  //////////////////////////////////////////////////

  // cycle count and run limit
  always @(posedge man) begin
    cyc <= cyc + 1;
    if (cyc >= limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("Some tests failed");
      $finish;
    end
  end

  // ready must never reach an idle initiator
  always @(posedge man) begin
    for (int i = 0; i < PN; i++) begin
      if (ini_rsp[i].rdy && !ini_req[i].vld) begin
        mon_errs++;
        $display("initiator %0d was granted without a valid request", i);
      end
    end
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic check(input string name, input string field,
                       input logic [DW-1:0] exp, input logic [DW-1:0] act);
    if (exp !== act) begin
      val_errs++;
      $display("** Error %s %s: expected %h, actual %h", name, field, exp, act);
    end
  endtask

  function automatic tcb_req_t make_req(input logic [31:0] v, input logic [31:0] w,
                                        input logic [31:0] a, input logic [31:0] b,
                                        input logic [31:0] d);
    tcb_req_t r;
    r.vld = v[0];
    r.wen = w[0];
    r.adr = a[AW-1:0];
    r.ben = b[BW-1:0];
    r.wdt = d[DW-1:0];
    return r;
  endfunction

  // columns per initiator: name vld wen adr ben wdt exp_rdt exp_err
  task automatic load_stim();
    int fd;
    int n;
    string line;
    logic [8*16-1:0] nm0, nm1;
    logic [31:0] v0, w0, a0, b0, d0, r0, e0;
    logic [31:0] v1, w1, a1, b1, d1, r1, e1;
    nsteps = 0;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      other_errs++;
      $display("could not open the stimulus file %s", STIM_FILE);
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %h %h %h %h %h %h %h %s %h %h %h %h %h %h %h",
                      nm0, v0, w0, a0, b0, d0, r0, e0,
                      nm1, v1, w1, a1, b1, d1, r1, e1);
          if (n == 16 && nsteps < MAX_STEPS) begin
            stim_name[nsteps][0] = string'(nm0);
            stim_name[nsteps][1] = string'(nm1);
            stim_req[nsteps][0]  = make_req(v0, w0, a0, b0, d0);
            stim_req[nsteps][1]  = make_req(v1, w1, a1, b1, d1);
            stim_rdt[nsteps][0]  = r0[DW-1:0];
            stim_rdt[nsteps][1]  = r1[DW-1:0];
            stim_err[nsteps][0]  = e0[0];
            stim_err[nsteps][1]  = e1[0];
            nsteps++;
          end else if (n > 0) begin
            other_errs++;
            $display("stimulus line could not be used: %s", line);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // no response data or error on any port
  task automatic expect_idle_bus(input string name);
    for (int i = 0; i < PN; i++) begin
      check(name, $sformatf("ini%0d rdt", i), '0, ini_rsp[i].rdt);
      check(name, $sformatf("ini%0d err", i), '0, DW'(ini_rsp[i].err));
    end
  endtask

  // called on a falling edge, returns on a falling edge
  task automatic drive_initiator(input int i, input int s);
    string nm;
    nm = stim_name[s][i];
    ini_req[i] = stim_req[s][i];
    if (stim_req[s][i].vld) begin
      // request held until ready shows at a rising edge
      @(posedge man);
      while (!ini_rsp[i].rdy) begin
        @(negedge man);
        @(posedge man);
      end
      done_cyc[i] = cyc;
      // response registered at the transfer edge, stable by mid-cycle
      @(negedge man);
      check(nm, $sformatf("ini%0d rdt", i), stim_rdt[s][i], ini_rsp[i].rdt);
      check(nm, $sformatf("ini%0d err", i), DW'(stim_err[s][i]), DW'(ini_rsp[i].err));
      ini_req[i] = '0;
    end
  endtask

  task automatic run_step(input int s);
    for (int i = 0; i < PN; i++) begin
      done_cyc[i] = 0;
    end
    // one driver per initiator
    fork
      drive_initiator(0, s);
      drive_initiator(1, s);
    join
    // lower rank in PRI must transfer earlier
    for (int k = 0; k + 1 < PN; k++) begin
      if (stim_req[s][PRI[k]].vld && stim_req[s][PRI[k+1]].vld) begin
        check(stim_name[s][PRI[k+1]], "order", DW'(1),
              DW'(done_cyc[PRI[k]] < done_cyc[PRI[k+1]]));
      end
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    man   = 1'b0;
    rst_n = 1'b0;
    for (int i = 0; i < PN; i++) begin
      ini_req[i] = '0;
    end
    load_stim();
    if (nsteps == 0) begin
      other_errs++;
      $display("no usable stimulus lines were found");
    end
    limit = nsteps * 8 + 100;
    // outputs quiet while in reset
    repeat (RST_CYC) begin
      @(negedge man);
      expect_idle_bus("reset");
    end
    rst_n = 1'b1;
    repeat (2) begin
      @(negedge man);
      expect_idle_bus("after_reset");
    end
    for (int s = 0; s < nsteps; s++) begin
      run_step(s);
    end
    repeat (2) @(negedge man);
    $display("errors: %0d value mismatches, %0d other failures",
             val_errs, other_errs + mon_errs);
    if (val_errs == 0 && other_errs + mon_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: testbench/tcb_sys_props.sv
// concurrent assertions bound into the tcb arbiter
// grant exclusivity, ready qualification, target valid

module tcb_sys_props (
  input logic               man,
  input logic               rst_n,
  input tcb_pkg::tcb_req_t  ini_req [tcb_pkg::PN],
  input tcb_pkg::tcb_rsp_t  ini_rsp [tcb_pkg::PN],
  input tcb_pkg::tcb_req_t  tgt_req
);

  import tcb_pkg::*;

  // flattened per-initiator flags
  logic [PN-1:0] vld_vec;
  logic [PN-1:0] rdy_vec;

  always_comb begin
    for (int i = 0; i < PN; i++) begin
      vld_vec[i] = ini_req[i].vld;
      rdy_vec[i] = ini_rsp[i].rdy;
    end
  end

  //////////////////////////////////////////////////
  // properties
  //////////////////////////////////////////////////

  // one grant at a time
  grant_onehot: assert property (@(posedge man) disable iff (!rst_n) $onehot0(rdy_vec))
    else $error("more than one initiator sees ready");

  // ready only where a request stands
  grant_valid: assert property (@(posedge man) disable iff (!rst_n)
                                (rdy_vec & ~vld_vec) == '0)
    else $error("ready given to an initiator without a request");

  // some request always reaches the target
  tgt_valid: assert property (@(posedge man) disable iff (!rst_n) |vld_vec |-> tgt_req.vld)
    else $error("initiator request not forwarded to the target");

endmodule

bind tcb_arb tcb_sys_props props0 (
  .man     (man),
  .rst_n   (rst_n),
  .ini_req (ini_req),
  .ini_rsp (ini_rsp),
  .tgt_req (tgt_req)
);

// File: verilog/tcb_sys.sv
// tcb subsystem top level
// arbiter in front of one memory target, initiator ports brought out

module tcb_sys (
  input  logic               man,
  input  logic               rst_n,
  // initiator ports
  input  tcb_pkg::tcb_req_t  ini_req [tcb_pkg::PN],
  output tcb_pkg::tcb_rsp_t  ini_rsp [tcb_pkg::PN]
);

  import tcb_pkg::*;

  //////////////////////////////////////////////////
  // internal bus
  //////////////////////////////////////////////////

  // arbiter to memory request
  tcb_req_t tgt_req;
  // memory to arbiter response
  tcb_rsp_t tgt_rsp;

  //////////////////////////////////////////////////
  // arbiter
  //////////////////////////////////////////////////

  // fixed priority from PRI
  tcb_arb arb0 (
    .man     (man),
    .rst_n   (rst_n),
    .ini_req (ini_req),
    .ini_rsp (ini_rsp),
    .tgt_req (tgt_req),
    .tgt_rsp (tgt_rsp)
  );

  //////////////////////////////////////////////////
  // memory target
  //////////////////////////////////////////////////

  // MEM_WORDS words, stalls one cycle after writes
  tcb_mem mem0 (
    .man   (man),
    .rst_n (rst_n),
    .req   (tgt_req),
    .rsp   (tgt_rsp)
  );

endmodule

// File: verilog/tcb_mem.sv
// byte-enabled memory target on the tcb bus
// one-cycle registered response, address range error, write recovery stall

module tcb_mem (
  input  logic               man,
  input  logic               rst_n,
  // bus target port
  input  tcb_pkg::tcb_req_t  req,
  output tcb_pkg::tcb_rsp_t  rsp
);

  import tcb_pkg::*;

  //////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////

  // word storage, no reset
  logic [DW-1:0]  mem [MEM_WORDS];

  // address decode
  logic [MAW-1:0] idx;
  logic           in_rng;

  // handshake
  logic           trn;
  logic           wr_acc;

  // write recovery flag, holds rdy low for one cycle
  logic           rec;

  // registered response
  logic [DW-1:0]  rsp_rdt;
  logic           rsp_err;

  //////////////////////////////////////////////////
  // address decode and handshake
  //////////////////////////////////////////////////

  // word index, upper address bits only matter for range check
  assign idx    = req.adr[MAW-1:0];
  assign in_rng = 32'(req.adr) < MEM_WORDS;

  // transfer when not recovering from a write
  assign trn    = req.vld & ~rec;

  // write that really lands in the array
  assign wr_acc = trn & req.wen & in_rng;

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////

  // byte lanes written under ben
  always_ff @(posedge man) begin
    if (wr_acc) begin
      for (int b = 0; b < BW; b++) begin
        if (req.ben[b]) begin
          mem[idx][8*b +: 8] <= req.wdt[8*b +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // write recovery
  //////////////////////////////////////////////////

  // set for exactly one cycle after each accepted write
  // trn is blocked while set, so it never stays high twice
  always_ff @(posedge man or negedge rst_n) begin
    if (!rst_n) begin
      rec <= 1'b0;
    end else begin
      rec <= wr_acc;
    end
  end

  //////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////

  // every transfer loads a new response
  // read in range returns the word, anything else zero data
  always_ff @(posedge man or negedge rst_n) begin
    if (!rst_n) begin
      rsp_rdt <= '0;
      rsp_err <= 1'b0;
    end else if (trn) begin
      // out of range reads and writes both flag
      rsp_err <= ~in_rng;
      if (in_rng && !req.wen) begin
        rsp_rdt <= mem[idx];
      end else begin
        rsp_rdt <= '0;
      end
    end
  end

  // pack outputs
  always_comb begin
    rsp.rdy = ~rec;
    rsp.rdt = rsp_rdt;
    rsp.err = rsp_err;
  end

endmodule

// File: verilog/tcb_arb.sv
// fixed-priority arbiter for the tcb subsystem
// priority encoder, request multiplexer, registered response router

module tcb_arb (
  input  logic               man,
  input  logic               rst_n,
  // initiator side
  input  tcb_pkg::tcb_req_t  ini_req [tcb_pkg::PN],
  output tcb_pkg::tcb_rsp_t  ini_rsp [tcb_pkg::PN],
  // target side
  output tcb_pkg::tcb_req_t  tgt_req,
  input  tcb_pkg::tcb_rsp_t  tgt_rsp
);

  import tcb_pkg::*;

  //////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////

  // valid flags reordered by priority rank
  logic [PN-1:0] rank_vld;
  // some initiator is requesting
  logic          any_vld;
  // current select, combinational
  logic [SW-1:0] sel;
  // owner of the pending response
  logic [SW-1:0] own;
  // transfer on the target port
  logic          trn;

  //////////////////////////////////////////////////
  // priority encoder
  //////////////////////////////////////////////////

  // lowest set rank wins
  // returns the rank, caller maps it back through PRI
  function automatic logic [SW-1:0] top_rank(input logic [PN-1:0] vld);
    logic [SW-1:0] rank;
    rank = '0;
    // walk downward so the last hit is the lowest rank
    for (int k = PN - 1; k >= 0; k--) begin
      if (vld[k]) begin
        rank = SW'(k);
      end
    end
    return rank;
  endfunction

  // valid flags in rank order
  always_comb begin
    for (int k = 0; k < PN; k++) begin
      rank_vld[k] = ini_req[PRI[k]].vld;
    end
  end

  assign any_vld = |rank_vld;

  // rank back to initiator index
  // with nothing valid this lands on PRI[0], a harmless idle select
  assign sel = SW'(PRI[top_rank(rank_vld)]);

  //////////////////////////////////////////////////
  // request multiplexer
  //////////////////////////////////////////////////

  // whole request group follows the select
  // vld is already 0 when no initiator is requesting
  assign tgt_req = ini_req[sel];

  // transfer when the target takes the muxed request
  assign trn = tgt_req.vld & tgt_rsp.rdy;

  //////////////////////////////////////////////////
  // grant register
  //////////////////////////////////////////////////

  // remember who got the transfer
  // response comes back one cycle later
  always_ff @(posedge man or negedge rst_n) begin
    if (!rst_n) begin
      own <= '0;
    end else if (trn) begin
      own <= sel;
    end
  end

  //////////////////////////////////////////////////
  // response router
  //////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < PN; i++) begin
      // request phase, ready only to the selected and valid initiator
      ini_rsp[i].rdy = (sel == SW'(i)) & any_vld & tgt_rsp.rdy;
      // response phase, data only to the owner of the last transfer
      if (own == SW'(i)) begin
        ini_rsp[i].rdt = tgt_rsp.rdt;
        ini_rsp[i].err = tgt_rsp.err;
      end else begin
        // non-owners see a quiet bus
        ini_rsp[i].rdt = '0;
        ini_rsp[i].err = 1'b0;
      end
    end
  end

  // note: a higher-priority request arriving during a target stall
  // simply changes sel, the stalled initiator keeps holding its request
  // and gets its turn in a later cycle

endmodule

// File: verilog/tcb_pkg.sv
// shared bus definitions for the tcb subsystem
// widths, port count, priority table, memory size, request/response structs

package tcb_pkg;

  //////////////////////////////////////////////////
  // bus widths
  //////////////////////////////////////////////////

  // word address width
  localparam int unsigned AW = 8;
  // data width
  localparam int unsigned DW = 32;
  // byte enable width, one bit per byte lane
  localparam int unsigned BW = DW / 8;

  //////////////////////////////////////////////////
  // interconnect
  //////////////////////////////////////////////////

  // number of initiators
  localparam int unsigned PN = 2;
  // grant index width, never below one bit
  localparam int unsigned SW = (PN > 1) ? $clog2(PN) : 1;
  // entry k holds the initiator index at rank k, rank 0 wins
  localparam int unsigned PRI [PN] = '{0, 1};

  //////////////////////////////////////////////////
  // memory target
  //////////////////////////////////////////////////

  // word count, addresses at or above are errors
  localparam int unsigned MEM_WORDS = 128;
  // index width into the word array
  localparam int unsigned MAW = $clog2(MEM_WORDS);

  //////////////////////////////////////////////////
  // bus signal groups
  //////////////////////////////////////////////////

  // request phase, driven by the initiator
  typedef struct packed {
    logic          vld;  // valid
    logic          wen;  // write enable
    logic [AW-1:0] adr;  // word address
    logic [BW-1:0] ben;  // byte enables
    logic [DW-1:0] wdt;  // write data
  } tcb_req_t;

  // rdy belongs to the request phase
  // rdt and err arrive one cycle after the transfer
  typedef struct packed {
    logic          rdy;  // ready
    logic [DW-1:0] rdt;  // read data
    logic          err;  // error flag
  } tcb_rsp_t;

endpackage
